//--- all.f
hw/conv_data_pkg.sv
hw/conv_ctrl_pkg.sv
hw/conv_blk_ctrl.sv
hw/kwgt_buf.sv
hw/mac_array.sv
hw/bn_proc.sv
hw/bn_param_ram.sv
hw/conv_core_top.sv
tb/tb_conv_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_conv_core
FLAGS ?= --binary --timing --assert -Wno-fatal
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f all.f
	out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)

//--- tb/tb_conv_core.sv
`timescale 1ns/1ps

module tb_conv_core
	import conv_data_pkg::*;
	import conv_ctrl_pkg::*;
();
	localparam int K = 4;
	localparam int C = 4;
	localparam int G = 8;
	localparam int KW = 2;
	localparam int PT_MAX = 4;
	localparam int BEAT_LIMIT = 2000;
	localparam int DONE_LIMIT = 5000;

	logic            aclk;
	logic            reset_i;
	logic            blk_start_i;
	logic            blk_idle_o;
	logic            blk_done_o;
	cgrp_cnt_t       cgrp_n_i;
	point_cnt_t      point_n_i;
	accrc_t          bn_accrc_i;
	logic            bn_is_a_eq_1_i;
	logic            bn_is_b_eq_0_i;
	logic            bn_mem_wen_i;
	logic [KW-1:0]   bn_mem_addr_i;
	bn_word_t        bn_mem_din_i;
	wgt_t [C-1:0]    kwgt_data_i;
	logic            kwgt_last_i;
	logic            kwgt_valid_i;
	logic            kwgt_ready_o;
	feat_t [C-1:0]   fmap_data_i;
	logic            fmap_valid_i;
	logic            fmap_ready_o;
	sum_t            res_data_o;
	logic [KW-1:0]   res_kidx_o;
	logic            res_last_o;
	logic            res_valid_o;
	logic            res_ready_i;

	wgt_t            wgt_ref [G][K][C];
	feat_t           feat_ref [PT_MAX][G][C];
	bn_coef_t        bn_a [K];
	bn_coef_t        bn_b [K];
	logic [34:0]     exp_q [$]; // {last, kidx, data}
	logic            exp_avail;
	sum_t            exp_data;
	logic [KW-1:0]   exp_kidx;
	logic            exp_last;
	logic            pend_pop;
	logic [31:0]     stim_seed;
	logic [31:0]     bp_seed;
	logic            bp_en;
	int              err_cnt;
	int              test_cnt;
	int              test_fail_cnt;
	int              test_err_base;
	int              done_cnt;
	bit              timeout_hit;
	string           test_name;

	conv_core_top #(
		.ATOMIC_K   (K),
		.ATOMIC_C   (C),
		.MAX_CGRP_N (G)
	) i_conv_core_top (.*);

	always #4 aclk = ~aclk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		stim_seed = xorshift(stim_seed);
		return stim_seed;
	endfunction

	// BN rule applied to one kernel sum
	function automatic sum_t bn_ref(input sum_t s, input bn_coef_t a, input bn_coef_t b,
		input accrc_t sh, input bit a1, input bit b0);
		logic signed [63:0] p;
		sum_t               r;
		p = $signed({{32{a[31]}}, a}) * $signed({{32{s[31]}}, s});
		p = p >>> sh;
		r = a1 ? s : sum_t'(p[31:0]);
		if (!b0)
			r = r + b;
		return r;
	endfunction

	// random back-pressure on the result stream
	always @(posedge aclk)
	begin
		#1;
		if (bp_en)
		begin
			bp_seed = xorshift(bp_seed);
			res_ready_i = (bp_seed[3:0] > 4'd5);
		end
		else
			res_ready_i = 1'b1;
	end

	// head of the expected queue, stable around each rising edge
	always @(negedge aclk)
	begin
		if (pend_pop)
			void'(exp_q.pop_front());
		if (blk_done_o === 1'b1)
			done_cnt++;
		exp_avail = (exp_q.size() > 0);
		if (exp_avail)
			{exp_last, exp_kidx, exp_data} = exp_q[0];
		pend_pop = res_valid_o && res_ready_i && exp_avail && !reset_i;
	end

	assert property (@(posedge aclk) disable iff (reset_i)
		(res_valid_o && res_ready_i) |-> exp_avail)
	else
	begin
		err_cnt++;
		$display("result beat arrived in %s while no result was expected", test_name);
	end

	assert property (@(posedge aclk) disable iff (reset_i)
		(res_valid_o && res_ready_i && exp_avail) |-> (res_data_o == exp_data))
	else
	begin
		err_cnt++;
		$display("CHECK FAILED %s: res_data_o expected %0d actual %0d",
			test_name, exp_data, $sampled(res_data_o));
	end

	assert property (@(posedge aclk) disable iff (reset_i)
		(res_valid_o && res_ready_i && exp_avail) |-> (res_kidx_o == exp_kidx))
	else
	begin
		err_cnt++;
		$display("CHECK FAILED %s: res_kidx_o expected %0d actual %0d",
			test_name, exp_kidx, $sampled(res_kidx_o));
	end

	assert property (@(posedge aclk) disable iff (reset_i)
		(res_valid_o && res_ready_i && exp_avail) |-> (res_last_o == exp_last))
	else
	begin
		err_cnt++;
		$display("CHECK FAILED %s: res_last_o expected %0b actual %0b",
			test_name, exp_last, $sampled(res_last_o));
	end

	// weights load only while idle, features never while idle
	assert property (@(posedge aclk) disable iff (reset_i)
		(kwgt_ready_o == blk_idle_o) && !(fmap_ready_o && blk_idle_o))
	else
	begin
		err_cnt++;
		$display("a stream ready in %s did not match the block state", test_name);
	end

	assert property (@(posedge aclk) disable iff (reset_i)
		blk_done_o |-> (blk_idle_o && !exp_avail))
	else
	begin
		err_cnt++;
		$display("blk_done_o pulsed in %s before all results were out", test_name);
	end

	task automatic step_cycle();
		@(posedge aclk);
		#1;
	endtask

	task automatic check_bit(input string sig, input logic exp, input logic act);
		assert (act === exp)
		else
		begin
			err_cnt++;
			$display("CHECK FAILED %s: %s expected %0b actual %0b", test_name, sig, exp, act);
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_err_base = err_cnt;
		test_cnt++;
	endtask

	task automatic end_test();
		if (err_cnt == test_err_base)
			$display("test %s: ok", test_name);
		else
		begin
			test_fail_cnt++;
			$display("test %s: %0d errors", test_name, err_cnt - test_err_base);
		end
	endtask

	// beat transfers on the next edge if ready is seen at the falling edge
	task automatic wait_beat(input bit wgt_side, input int idx);
		int   wait_n;
		logic fired;
		wait_n = 0;
		fired = 1'b0;
		while (!fired && !timeout_hit)
		begin
			@(negedge aclk);
			fired = wgt_side ? kwgt_ready_o : fmap_ready_o;
			step_cycle();
			wait_n++;
			if (!fired && wait_n >= BEAT_LIMIT)
			begin
				$display("timeout: %s beat %0d was never accepted",
					wgt_side ? "weight" : "feature", idx);
				timeout_hit = 1'b1;
			end
		end
	endtask

	task automatic load_weights();
		for (int g = 0; g < G; g++)
			for (int k = 0; k < K; k++)
				for (int c = 0; c < C; c++)
					wgt_ref[g][k][c] = wgt_t'(next_rand());
		for (int n = 0; n < G * K; n++)
		begin
			for (int c = 0; c < C; c++)
				kwgt_data_i[c] = wgt_ref[n / K][n % K][c]; // kernel-major within a group
			kwgt_last_i = (n == G * K - 1);
			kwgt_valid_i = 1'b1;
			wait_beat(1'b1, n);
		end
		kwgt_valid_i = 1'b0;
		kwgt_last_i = 1'b0;
	endtask

	task automatic write_bn_params();
		for (int k = 0; k < K; k++)
		begin
			bn_a[k] = bn_coef_t'(next_rand()); // full range, so negative A too
			bn_b[k] = bn_coef_t'(next_rand());
			bn_mem_wen_i = 1'b1;
			bn_mem_addr_i = KW'(k);
			bn_mem_din_i = {bn_b[k], bn_a[k]};
			step_cycle();
		end
		bn_mem_wen_i = 1'b0;
	endtask

	task automatic run_block(input int pts, input int grps, input accrc_t sh,
		input bit a1, input bit b0);
		int   base;
		int   wait_n;
		sum_t acc;
		sum_t prod;
		base = done_cnt;
		for (int p = 0; p < pts; p++)
		begin
			for (int g = 0; g < grps; g++)
				for (int c = 0; c < C; c++)
					feat_ref[p][g][c] = feat_t'(next_rand());
			for (int k = 0; k < K; k++)
			begin
				acc = '0;
				for (int g = 0; g < grps; g++)
					for (int c = 0; c < C; c++)
					begin
						prod = feat_ref[p][g][c] * wgt_ref[g][k][c];
						acc = acc + prod; // wraps at 32 bits
					end
				exp_q.push_back({k == K - 1, KW'(k), bn_ref(acc, bn_a[k], bn_b[k], sh, a1, b0)});
			end
		end
		cgrp_n_i = cgrp_cnt_t'(grps - 1);
		point_n_i = point_cnt_t'(pts - 1);
		bn_accrc_i = sh;
		bn_is_a_eq_1_i = a1;
		bn_is_b_eq_0_i = b0;
		blk_start_i = 1'b1;
		step_cycle();
		blk_start_i = 1'b0;
		for (int p = 0; p < pts; p++)
			for (int g = 0; g < grps; g++)
			begin
				for (int c = 0; c < C; c++)
					fmap_data_i[c] = feat_ref[p][g][c];
				fmap_valid_i = 1'b1;
				wait_beat(1'b0, p * grps + g);
			end
		fmap_valid_i = 1'b0;
		wait_n = 0;
		while (done_cnt == base && !timeout_hit)
		begin
			step_cycle();
			wait_n++;
			if (wait_n >= DONE_LIMIT)
			begin
				$display("timeout: blk_done_o never pulsed in %s", test_name);
				timeout_hit = 1'b1;
			end
		end
		repeat (4) step_cycle();
		if (!timeout_hit)
		begin
			assert (done_cnt == base + 1)
			else
			begin
				err_cnt++;
				$display("CHECK FAILED %s: done pulses expected 1 actual %0d",
					test_name, done_cnt - base);
			end
			assert (exp_q.size() == 0)
			else
			begin
				err_cnt++;
				$display("CHECK FAILED %s: missing results expected 0 actual %0d",
					test_name, exp_q.size());
			end
			check_bit("blk_idle_o", 1'b1, blk_idle_o);
		end
	endtask

	initial
	begin
		aclk = 1'b0;
		reset_i = 1'b1;
		blk_start_i = 1'b0;
		cgrp_n_i = '0;
		point_n_i = '0;
		bn_accrc_i = '0;
		bn_is_a_eq_1_i = 1'b0;
		bn_is_b_eq_0_i = 1'b0;
		bn_mem_wen_i = 1'b0;
		bn_mem_addr_i = '0;
		bn_mem_din_i = '0;
		kwgt_data_i = '0;
		kwgt_last_i = 1'b0;
		kwgt_valid_i = 1'b0;
		fmap_data_i = '0;
		fmap_valid_i = 1'b0;
		res_ready_i = 1'b1;
		bp_en = 1'b0;
		stim_seed = 32'h72c284c0;
		bp_seed = xorshift(32'h72c284c0);
		exp_avail = 1'b0;
		pend_pop = 1'b0;
		err_cnt = 0;
		test_cnt = 0;
		test_fail_cnt = 0;
		done_cnt = 0;
		timeout_hit = 1'b0;
		repeat (5) @(posedge aclk);
		#1;
		reset_i = 1'b0;

		begin_test("reset_state");
		@(negedge aclk);
		check_bit("blk_idle_o", 1'b1, blk_idle_o);
		check_bit("blk_done_o", 1'b0, blk_done_o);
		check_bit("res_valid_o", 1'b0, res_valid_o);
		check_bit("fmap_ready_o", 1'b0, fmap_ready_o);
		check_bit("sums_valid", 1'b0, i_conv_core_top.sums_valid);
		step_cycle();
		end_test();

		if (!timeout_hit)
		begin
			begin_test("single_point");
			load_weights();
			run_block(1, 1, accrc_t'(0), 1'b1, 1'b1); // plain dot product
			end_test();
		end
		if (!timeout_hit)
		begin
			begin_test("bn_full");
			write_bn_params();
			run_block(3, G, accrc_t'(13), 1'b0, 1'b0);
			end_test();
		end
		if (!timeout_hit)
		begin
			begin_test("backpressure");
			bp_en = 1'b1;
			run_block(4, G, accrc_t'(7), 1'b0, 1'b0);
			bp_en = 1'b0;
			end_test();
		end
		if (!timeout_hit)
		begin
			begin_test("weight_reload");
			load_weights();
			run_block(2, 3, accrc_t'(4), 1'b0, 1'b1);
			end_test();
		end

		$display("summary: %0d tests, %0d failed, %0d errors%s", test_cnt, test_fail_cnt,
			err_cnt, timeout_hit ? ", run stopped on a timeout" : "");
		if (err_cnt == 0 && !timeout_hit)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- hw/conv_core_top.sv
`timescale 1ns/1ps

module conv_core_top
	import conv_data_pkg::*;
	import conv_ctrl_pkg::*;
#(
	parameter int ATOMIC_K = 4,
	parameter int ATOMIC_C = 4,
	parameter int MAX_CGRP_N = 8,
	localparam int KW = (ATOMIC_K > 1) ? $clog2(ATOMIC_K) : 1
)(
	input  logic                 aclk,
	input  logic                 reset_i,

	input  logic                 blk_start_i,
	output logic                 blk_idle_o,
	output logic                 blk_done_o,

	input  cgrp_cnt_t            cgrp_n_i, // channel groups - 1
	input  point_cnt_t           point_n_i, // output points - 1
	input  accrc_t               bn_accrc_i,
	input  logic                 bn_is_a_eq_1_i,
	input  logic                 bn_is_b_eq_0_i,

	input  logic                 bn_mem_wen_i,
	input  logic [KW-1:0]        bn_mem_addr_i,
	input  bn_word_t             bn_mem_din_i, // {B, A}

	input  wgt_t [ATOMIC_C-1:0]  kwgt_data_i,
	input  logic                 kwgt_last_i,
	input  logic                 kwgt_valid_i,
	output logic                 kwgt_ready_o,

	input  feat_t [ATOMIC_C-1:0] fmap_data_i,
	input  logic                 fmap_valid_i,
	output logic                 fmap_ready_o,

	output sum_t                 res_data_o,
	output logic [KW-1:0]        res_kidx_o,
	output logic                 res_last_o,
	output logic                 res_valid_o,
	input  logic                 res_ready_i
);
	logic                             wgt_load_en;
	logic                             beat_take;
	logic                             grp_first;
	logic                             grp_last;
	cgrp_cnt_t                        cgrp_idx;
	logic                             mac_in_ready;
	wgt_t [ATOMIC_K-1:0][ATOMIC_C-1:0] grp_wgt;
	sum_t [ATOMIC_K-1:0]              sums;
	logic                             sums_valid;
	logic                             sums_ready;
	logic                             point_done;
	logic                             bn_rd_en;
	logic [KW-1:0]                    bn_rd_addr;
	bn_word_t                         bn_rd_data;

	conv_blk_ctrl i_conv_blk_ctrl (
		.aclk           (aclk),
		.reset_i        (reset_i),
		.blk_start_i    (blk_start_i),
		.cgrp_n_i       (cgrp_n_i),
		.point_n_i      (point_n_i),
		.fmap_valid_i   (fmap_valid_i),
		.mac_in_ready_i (mac_in_ready),
		.point_done_i   (point_done),
		.blk_idle_o     (blk_idle_o),
		.blk_done_o     (blk_done_o),
		.wgt_load_en_o  (wgt_load_en),
		.fmap_ready_o   (fmap_ready_o),
		.beat_take_o    (beat_take),
		.grp_first_o    (grp_first),
		.grp_last_o     (grp_last),
		.cgrp_idx_o     (cgrp_idx)
	);

	kwgt_buf #(
		.ATOMIC_K   (ATOMIC_K),
		.ATOMIC_C   (ATOMIC_C),
		.MAX_CGRP_N (MAX_CGRP_N)
	) i_kwgt_buf (
		.aclk          (aclk),
		.reset_i       (reset_i),
		.wgt_load_en_i (wgt_load_en),
		.kwgt_data_i   (kwgt_data_i),
		.kwgt_last_i   (kwgt_last_i),
		.kwgt_valid_i  (kwgt_valid_i),
		.cgrp_idx_i    (cgrp_idx),
		.kwgt_ready_o  (kwgt_ready_o),
		.grp_wgt_o     (grp_wgt)
	);

	mac_array #(
		.ATOMIC_K (ATOMIC_K),
		.ATOMIC_C (ATOMIC_C)
	) i_mac_array (
		.aclk         (aclk),
		.reset_i      (reset_i),
		.fmap_data_i  (fmap_data_i),
		.grp_wgt_i    (grp_wgt),
		.beat_take_i  (beat_take),
		.grp_first_i  (grp_first),
		.grp_last_i   (grp_last),
		.sums_ready_i (sums_ready),
		.in_ready_o   (mac_in_ready),
		.sums_o       (sums),
		.sums_valid_o (sums_valid)
	);

	bn_proc #(
		.ATOMIC_K (ATOMIC_K)
	) i_bn_proc (
		.aclk            (aclk),
		.reset_i         (reset_i),
		.blk_start_i     (blk_start_i),
		.sums_i          (sums),
		.sums_valid_i    (sums_valid),
		.bn_accrc_i      (bn_accrc_i),
		.bn_is_a_eq_1_i  (bn_is_a_eq_1_i),
		.bn_is_b_eq_0_i  (bn_is_b_eq_0_i),
		.bn_rd_data_i    (bn_rd_data),
		.res_ready_i     (res_ready_i),
		.sums_ready_o    (sums_ready),
		.bn_rd_en_o      (bn_rd_en),
		.bn_rd_addr_o    (bn_rd_addr),
		.res_data_o      (res_data_o),
		.res_kidx_o      (res_kidx_o),
		.res_last_o      (res_last_o),
		.res_valid_o     (res_valid_o),
		.point_done_o    (point_done)
	);

	bn_param_ram #(
		.ATOMIC_K (ATOMIC_K)
	) i_bn_param_ram (
		.aclk    (aclk),
		.wen_i   (bn_mem_wen_i),
		.waddr_i (bn_mem_addr_i),
		.wdata_i (bn_mem_din_i),
		.ren_i   (bn_rd_en),
		.raddr_i (bn_rd_addr),
		.rdata_o (bn_rd_data)
	);

endmodule

//--- hw/bn_param_ram.sv
`timescale 1ns/1ps

module bn_param_ram
	import conv_data_pkg::*;
#(
	parameter int ATOMIC_K = 4,
	localparam int KW = (ATOMIC_K > 1) ? $clog2(ATOMIC_K) : 1
)(
	input  logic          aclk,
	input  logic          wen_i,
	input  logic [KW-1:0] waddr_i,
	input  bn_word_t      wdata_i,
	input  logic          ren_i,
	input  logic [KW-1:0] raddr_i,
	output bn_word_t      rdata_o
);
	bn_word_t mem [ATOMIC_K]; // one {B, A} pair per kernel

	always_ff @(posedge aclk)
	begin
		if (wen_i)
			mem[waddr_i] <= wdata_i;
	end

	always_ff @(posedge aclk)
	begin
		if (ren_i)
			rdata_o <= mem[raddr_i]; // holds while ren low
	end

endmodule

//--- hw/bn_proc.sv
`timescale 1ns/1ps

module bn_proc
	import conv_data_pkg::*;
	import conv_ctrl_pkg::*;
#(
	parameter int ATOMIC_K = 4,
	localparam int KW = (ATOMIC_K > 1) ? $clog2(ATOMIC_K) : 1
)(
	input  logic                aclk,
	input  logic                reset_i,
	input  logic                blk_start_i,
	input  sum_t [ATOMIC_K-1:0] sums_i,
	input  logic                sums_valid_i,
	input  accrc_t              bn_accrc_i,
	input  logic                bn_is_a_eq_1_i,
	input  logic                bn_is_b_eq_0_i,
	input  bn_word_t            bn_rd_data_i,
	input  logic                res_ready_i,
	output logic                sums_ready_o,
	output logic                bn_rd_en_o,
	output logic [KW-1:0]       bn_rd_addr_o,
	output sum_t                res_data_o,
	output logic [KW-1:0]       res_kidx_o,
	output logic                res_last_o,
	output logic                res_valid_o,
	output logic                point_done_o
);
	sum_t [ATOMIC_K-1:0]         sums_r;
	logic                        busy; // stepping through sums_r
	logic [KW-1:0]               kidx;
	logic                        is_last_k;
	logic                        adv;
	accrc_t                      accrc_r;
	logic                        a_eq_1_r;
	logic                        b_eq_0_r;
	logic                        r_vld;
	sum_t                        r_val;
	logic [KW-1:0]               r_kidx;
	logic [2:0]                  m_vld;
	sum_t [2:0]                  m_val;
	bn_coef_t [2:0]              m_b;
	logic [2:0][KW-1:0]          m_kidx;
	bn_coef_t                    coef_a;
	bn_coef_t                    coef_b;
	logic signed [BN_PROD_W-1:0] prod_1;
	logic signed [BN_PROD_W-1:0] prod_2;
	logic signed [BN_PROD_W-1:0] prod_3;
	logic signed [BN_PROD_W-1:0] shifted;
	sum_t                        scaled;

	assign adv          = !res_valid_o || res_ready_i; // frozen by output back-pressure
	assign is_last_k    = (kidx == KW'(ATOMIC_K - 1));
	assign sums_ready_o = adv && (!busy || is_last_k);
	assign bn_rd_en_o   = adv && busy;
	assign bn_rd_addr_o = kidx;
	assign point_done_o = res_valid_o && res_ready_i && res_last_o;

	assign coef_a  = bn_rd_data_i[31:0];
	assign coef_b  = bn_rd_data_i[63:32];
	assign shifted = prod_3 >>> accrc_r;
	assign scaled  = a_eq_1_r ? m_val[2] : sum_t'(shifted[31:0]);

	always_ff @(posedge aclk)
	begin
		if (reset_i)
		begin
			busy        <= 1'b0;
			kidx        <= '0;
			r_vld       <= 1'b0;
			m_vld       <= '0;
			res_valid_o <= 1'b0;
			accrc_r     <= '0;
			a_eq_1_r    <= 1'b0;
			b_eq_0_r    <= 1'b0;
		end
		else
		begin
			if (blk_start_i)
			begin
				accrc_r  <= bn_accrc_i;
				a_eq_1_r <= bn_is_a_eq_1_i;
				b_eq_0_r <= bn_is_b_eq_0_i;
			end
			if (adv)
			begin
				if (busy)
					kidx <= is_last_k ? '0 : kidx + 1'b1;
				if (sums_valid_i && sums_ready_o)
					busy <= 1'b1;
				else if (is_last_k)
					busy <= 1'b0;
				r_vld       <= busy;
				m_vld       <= {m_vld[1:0], r_vld};
				res_valid_o <= m_vld[2];
			end
		end
	end

	always_ff @(posedge aclk)
	begin
		if (sums_valid_i && sums_ready_o)
			sums_r <= sums_i;
		if (adv)
		begin
			r_val  <= sums_r[kidx];
			r_kidx <= kidx;

			// rd data belongs to the kernel in the read stage
			prod_1 <= coef_a * r_val;
			prod_2 <= prod_1;
			prod_3 <= prod_2;
			m_val  <= {m_val[1:0], r_val};
			m_b    <= {m_b[1:0], coef_b};
			m_kidx <= {m_kidx[1:0], r_kidx};

			res_data_o <= b_eq_0_r ? scaled : scaled + m_b[2];
			res_kidx_o <= m_kidx[2];
			res_last_o <= (m_kidx[2] == KW'(ATOMIC_K - 1));
		end
	end

endmodule

//--- hw/mac_array.sv
`timescale 1ns/1ps

module mac_array
	import conv_data_pkg::*;
#(
	parameter int ATOMIC_K = 4,
	parameter int ATOMIC_C = 4
)(
	input  logic                              aclk,
	input  logic                              reset_i,
	input  feat_t [ATOMIC_C-1:0]              fmap_data_i,
	input  wgt_t [ATOMIC_K-1:0][ATOMIC_C-1:0] grp_wgt_i,
	input  logic                              beat_take_i,
	input  logic                              grp_first_i,
	input  logic                              grp_last_i,
	input  logic                              sums_ready_i,
	output logic                              in_ready_o,
	output sum_t [ATOMIC_K-1:0]               sums_o,
	output logic                              sums_valid_o
);
	prod_t [ATOMIC_K-1:0][ATOMIC_C-1:0] prod_r;
	logic                              p_vld;
	logic                              p_first;
	logic                              p_last;
	sum_t [ATOMIC_K-1:0]               tree_c;
	sum_t [ATOMIC_K-1:0]               tree_r;
	logic                              t_vld;
	logic                              t_first;
	logic                              t_last;
	sum_t [ATOMIC_K-1:0]               acc_r;
	sum_t [ATOMIC_K-1:0]               acc_nxt;

	// whole pipe stalls while the hold register is full
	assign in_ready_o = !sums_valid_o || sums_ready_i;

	always_comb
	begin
		for (int k = 0; k < ATOMIC_K; k++)
		begin
			tree_c[k] = '0;
			for (int c = 0; c < ATOMIC_C; c++)
				tree_c[k] = tree_c[k] + prod_r[k][c]; // wraps at 32 bits
			acc_nxt[k] = t_first ? tree_r[k] : acc_r[k] + tree_r[k];
		end
	end

	always_ff @(posedge aclk)
	begin
		if (reset_i)
		begin
			p_vld        <= 1'b0;
			t_vld        <= 1'b0;
			sums_valid_o <= 1'b0;
		end
		else
		begin
			if (sums_valid_o && sums_ready_i)
				sums_valid_o <= 1'b0;
			if (in_ready_o)
			begin
				p_vld <= beat_take_i;
				t_vld <= p_vld;
				if (t_vld && t_last)
					sums_valid_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge aclk)
	begin
		if (in_ready_o)
		begin
			p_first <= grp_first_i;
			p_last  <= grp_last_i;
			for (int k = 0; k < ATOMIC_K; k++)
				for (int c = 0; c < ATOMIC_C; c++)
					prod_r[k][c] <= $signed(fmap_data_i[c]) * $signed(grp_wgt_i[k][c]);

			t_first <= p_first;
			t_last  <= p_last;
			tree_r  <= tree_c;

			if (t_vld && !t_last)
				acc_r <= acc_nxt;
			if (t_vld && t_last)
				sums_o <= acc_nxt; // point complete, straight to hold
		end
	end

endmodule

//--- hw/kwgt_buf.sv
`timescale 1ns/1ps

module kwgt_buf
	import conv_data_pkg::*;
	import conv_ctrl_pkg::*;
#(
	parameter int ATOMIC_K = 4,
	parameter int ATOMIC_C = 4,
	parameter int MAX_CGRP_N = 8
)(
	input  logic                              aclk,
	input  logic                              reset_i,
	input  logic                              wgt_load_en_i,
	input  wgt_t [ATOMIC_C-1:0]               kwgt_data_i,
	input  logic                              kwgt_last_i,
	input  logic                              kwgt_valid_i,
	input  cgrp_cnt_t                         cgrp_idx_i,
	output logic                              kwgt_ready_o,
	output wgt_t [ATOMIC_K-1:0][ATOMIC_C-1:0] grp_wgt_o
);
	localparam int ROW_N = MAX_CGRP_N * ATOMIC_K;
	localparam int PTR_W = (ROW_N > 1) ? $clog2(ROW_N) : 1;

	wgt_t [ATOMIC_C-1:0] wgt_mem [ROW_N]; // row = cgrp * ATOMIC_K + kernel
	logic [PTR_W-1:0]    wr_ptr;
	logic                wr_fire;

	assign kwgt_ready_o = wgt_load_en_i;
	assign wr_fire      = kwgt_valid_i && kwgt_ready_o;

	always_ff @(posedge aclk)
	begin
		if (reset_i)
			wr_ptr <= '0;
		else if (wr_fire)
		begin
			if (kwgt_last_i || wr_ptr == PTR_W'(ROW_N - 1))
				wr_ptr <= '0; // block end
			else
				wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge aclk)
	begin
		if (wr_fire)
			wgt_mem[wr_ptr] <= kwgt_data_i;
	end

	// all kernels of the selected group at once
	always_comb
	begin
		for (int k = 0; k < ATOMIC_K; k++)
			grp_wgt_o[k] = wgt_mem[int'(cgrp_idx_i) * ATOMIC_K + k];
	end

endmodule

//--- hw/conv_blk_ctrl.sv
`timescale 1ns/1ps

module conv_blk_ctrl
	import conv_ctrl_pkg::*;
(
	input  logic       aclk,
	input  logic       reset_i,
	input  logic       blk_start_i,
	input  cgrp_cnt_t  cgrp_n_i,
	input  point_cnt_t point_n_i,
	input  logic       fmap_valid_i,
	input  logic       mac_in_ready_i,
	input  logic       point_done_i,
	output logic       blk_idle_o,
	output logic       blk_done_o,
	output logic       wgt_load_en_o,
	output logic       fmap_ready_o,
	output logic       beat_take_o,
	output logic       grp_first_o,
	output logic       grp_last_o,
	output cgrp_cnt_t  cgrp_idx_o
);
	blk_state_e state;
	cgrp_cnt_t  cgrp_n_r;
	cgrp_cnt_t  cgrp_cnt; // group within current input point
	point_cnt_t point_n_r;
	point_cnt_t in_pt_cnt; // points fed to the array
	point_cnt_t out_pt_cnt; // points fully written out
	logic       done_r;

	assign fmap_ready_o  = (state == RUN) && mac_in_ready_i;
	assign beat_take_o   = fmap_ready_o && fmap_valid_i;
	assign grp_first_o   = (cgrp_cnt == '0);
	assign grp_last_o    = (cgrp_cnt == cgrp_n_r);
	assign cgrp_idx_o    = cgrp_cnt;
	assign wgt_load_en_o = (state == IDLE); // weights only change between runs
	assign blk_idle_o    = (state == IDLE);
	assign blk_done_o    = done_r;

	always_ff @(posedge aclk)
	begin
		if (reset_i)
		begin
			state      <= IDLE;
			cgrp_n_r   <= '0;
			point_n_r  <= '0;
			cgrp_cnt   <= '0;
			in_pt_cnt  <= '0;
			out_pt_cnt <= '0;
			done_r     <= 1'b0;
		end
		else
		begin
			done_r <= 1'b0;
			unique case (state)
				IDLE:
				begin
					if (blk_start_i)
					begin
						cgrp_n_r   <= cgrp_n_i;
						point_n_r  <= point_n_i;
						cgrp_cnt   <= '0;
						in_pt_cnt  <= '0;
						out_pt_cnt <= '0;
						state      <= RUN;
					end
				end
				RUN:
				begin
					if (beat_take_o && grp_last_o && in_pt_cnt == point_n_r)
						state <= DRAIN; // last feature beat in
				end
				DRAIN:
				begin
				end
				default:
				begin
					state <= IDLE;
				end
			endcase

			if (beat_take_o)
			begin
				if (grp_last_o)
				begin
					cgrp_cnt  <= '0;
					in_pt_cnt <= in_pt_cnt + 1'b1;
				end
				else
					cgrp_cnt <= cgrp_cnt + 1'b1;
			end

			// output side, final point ends the run
			if (point_done_i && state != IDLE)
			begin
				out_pt_cnt <= out_pt_cnt + 1'b1;
				if (out_pt_cnt == point_n_r)
				begin
					state  <= IDLE;
					done_r <= 1'b1;
				end
			end
		end
	end

endmodule

//--- hw/conv_ctrl_pkg.sv
package conv_ctrl_pkg;

	// block control states
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		RUN   = 2'd1,
		DRAIN = 2'd2 // all beats in, waiting for results
	} blk_state_e;

	// channel group index or count
	typedef logic [7:0] cgrp_cnt_t;

	// output point count
	typedef logic [15:0] point_cnt_t;

	// BN fixed-point shift
	typedef logic [4:0] accrc_t;

endpackage

//--- hw/conv_data_pkg.sv
package conv_data_pkg;

	// one signed feature value
	typedef logic signed [15:0] feat_t;

	// one signed weight value
	typedef logic signed [15:0] wgt_t;

	// feature times weight
	typedef logic signed [31:0] prod_t;

	// accumulated kernel sum, also the final result
	typedef logic signed [31:0] sum_t;

	// BN coefficient A or B
	typedef logic signed [31:0] bn_coef_t;

	// BN memory word {B, A}
	typedef logic [63:0] bn_word_t;

	// A times sum before the shift
	localparam int BN_PROD_W = 64;

endpackage
